/* hdl/x86_arch_pkg.sv */
/*
 * x86 architectural constants: register file geometry, operand size
 * and operand kind encodings, segment numbers and the ModRM byte view
 */
`default_nettype none

package x86_arch_pkg;

    // General purpose registers
    localparam int GPR_COUNT     = 8;
    localparam int GPR_WIDTH     = 32;
    localparam int GPR_BYTES     = GPR_WIDTH / 8;
    localparam int REG_NUM_WIDTH = 3;

    // Segment and MMX register files
    localparam int SEG_COUNT = 6;
    localparam int SEG_WIDTH = 16;
    localparam int MMX_COUNT = 8;
    localparam int MMX_WIDTH = 64;

    // Size codes other than these three write nothing
    localparam int SIZE_WIDTH = 3;
    localparam logic [SIZE_WIDTH-1:0] SIZE_BYTE  = 3'd0;
    localparam logic [SIZE_WIDTH-1:0] SIZE_WORD  = 3'd1;
    localparam logic [SIZE_WIDTH-1:0] SIZE_DWORD = 3'd2;

    // Operand kind that takes its register from ModRM.reg
    localparam int OPK_WIDTH = 3;
    localparam logic [OPK_WIDTH-1:0] OPK_MODRM_REG = 3'd4;

    // Segment register numbers
    localparam logic [REG_NUM_WIDTH-1:0] SEG_ES = 3'd0;
    localparam logic [REG_NUM_WIDTH-1:0] SEG_CS = 3'd1;
    localparam logic [REG_NUM_WIDTH-1:0] SEG_SS = 3'd2;
    localparam logic [REG_NUM_WIDTH-1:0] SEG_DS = 3'd3;
    localparam logic [REG_NUM_WIDTH-1:0] SEG_FS = 3'd4;
    localparam logic [REG_NUM_WIDTH-1:0] SEG_GS = 3'd5;

    // ModRM byte seen raw or split into mod, reg/opcode and rm
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] mod;
            logic [2:0] reg_op;
            logic [2:0] rm;
        } f;
    } modrm_u;

endpackage

`default_nettype wire

/* hdl/ra_pipe_pkg.sv */
/*
 * Field widths of the instruction word passed from register access
 * to address generation, and the segment used without an override
 */
`default_nettype none

package ra_pipe_pkg;

    // Instruction payload widths
    localparam int IMM_WIDTH    = 32;
    localparam int DISP_WIDTH   = 32;
    localparam int ALU_OP_WIDTH = 4;
    localparam int PC_WIDTH     = 32;

    // Data accesses fall back to DS
    localparam logic [x86_arch_pkg::REG_NUM_WIDTH-1:0] DEFAULT_SEG =
        x86_arch_pkg::SEG_DS;

endpackage

`default_nettype wire

/* hdl/gpr_wb_decode.sv */
/*
 * General register writeback decoder: turns one sized write into a
 * byte enable mask per register and lane aligned write data
 */
`timescale 1ns/1ps
`default_nettype none

module gpr_wb_decode (
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0]                   wb_reg_number,
    input  wire                                                      wb_reg_en,
    input  wire  [x86_arch_pkg::SIZE_WIDTH-1:0]                      wb_reg_size,
    input  wire  [x86_arch_pkg::GPR_WIDTH-1:0]                       wb_reg_data,
    output logic [x86_arch_pkg::GPR_COUNT-1:0][x86_arch_pkg::GPR_BYTES-1:0] wr_mask,
    output logic [x86_arch_pkg::GPR_WIDTH-1:0]                       wr_lanes
);

    import x86_arch_pkg::*;

    logic [REG_NUM_WIDTH-1:0] target;
    logic [GPR_BYTES-1:0]     lane_en;

    // Size and numbering rules pick the target register and its lanes
    always_comb begin
        target   = wb_reg_number;
        lane_en  = '0;
        wr_lanes = wb_reg_data;
        case (wb_reg_size)
            SIZE_BYTE: begin
                if (wb_reg_number[2]) begin
                    // AH, CH, DH, BH are byte 1 of EAX..EBX
                    target         = {1'b0, wb_reg_number[1:0]};
                    lane_en        = 4'b0010;
                    wr_lanes[15:8] = wb_reg_data[7:0];
                end else begin
                    lane_en = 4'b0001;
                end
            end
            SIZE_WORD:  lane_en = 4'b0011;
            SIZE_DWORD: lane_en = 4'b1111;
            default:    lane_en = '0;
        endcase
    end

    // One hot fan out of the lane enables
    always_comb begin
        for (int r = 0; r < GPR_COUNT; r++) begin
            wr_mask[r] = (wb_reg_en && target == REG_NUM_WIDTH'(r)) ? lane_en : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/gpr_entry.sv */
/*
 * One 32-bit general register, replacing only the enabled byte lanes
 */
`timescale 1ns/1ps
`default_nettype none

module gpr_entry (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [x86_arch_pkg::GPR_BYTES-1:0]  wr_byte_en,
    input  wire  [x86_arch_pkg::GPR_WIDTH-1:0]  wr_lanes,
    output logic [x86_arch_pkg::GPR_WIDTH-1:0]  value
);

    import x86_arch_pkg::*;

    // Byte lane merge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
        end else begin
            for (int b = 0; b < GPR_BYTES; b++) begin
                if (wr_byte_en[b]) begin
                    value[8*b +: 8] <= wr_lanes[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/seg_mmx_register_file.sv */
/*
 * Segment and MMX register files. Each has one write port; one segment
 * and two MMX registers are read combinationally
 */
`timescale 1ns/1ps
`default_nettype none

module seg_mmx_register_file (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0]  wb_seg_number,
    input  wire                                     wb_seg_en,
    input  wire  [x86_arch_pkg::SEG_WIDTH-1:0]      wb_seg_data,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0]  wb_mmx_number,
    input  wire                                     wb_mmx_en,
    input  wire  [x86_arch_pkg::MMX_WIDTH-1:0]      wb_mmx_data,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0]  seg_select,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0]  mmx_read0,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0]  mmx_read1,
    output logic [x86_arch_pkg::SEG_WIDTH-1:0]      seg_val,
    output logic [x86_arch_pkg::MMX_WIDTH-1:0]      mmx_val0,
    output logic [x86_arch_pkg::MMX_WIDTH-1:0]      mmx_val1
);

    import x86_arch_pkg::*;

    logic [SEG_WIDTH-1:0] seg_q [SEG_COUNT];
    logic [MMX_WIDTH-1:0] mmx_q [MMX_COUNT];

    // Segment numbers above GS do not exist and are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SEG_COUNT; s++) begin
                seg_q[s] <= '0;
            end
        end else if (wb_seg_en && (wb_seg_number <= SEG_GS)) begin
            seg_q[wb_seg_number] <= wb_seg_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int m = 0; m < MMX_COUNT; m++) begin
                mmx_q[m] <= '0;
            end
        end else if (wb_mmx_en) begin
            mmx_q[wb_mmx_number] <= wb_mmx_data;
        end
    end

    // Reads return the pre-write value in the write cycle
    assign seg_val  = (seg_select <= SEG_GS) ? seg_q[seg_select] : '0;
    assign mmx_val0 = mmx_q[mmx_read0];
    assign mmx_val1 = mmx_q[mmx_read1];

endmodule

`default_nettype wire

/* hdl/ra_pipe_reg.sv */
/*
 * One-entry valid/ready pipeline register with flush, holding the
 * instruction fields and operand values for address generation
 */
`timescale 1ns/1ps
`default_nettype none

module ra_pipe_reg (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    flush,
    input  wire                                    in_valid,
    output logic                                   in_ready,
    input  wire  [x86_arch_pkg::SIZE_WIDTH-1:0]    in_size,
    input  wire  [x86_arch_pkg::OPK_WIDTH-1:0]     in_op0,
    input  wire  [x86_arch_pkg::OPK_WIDTH-1:0]     in_op1,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] in_op0_reg,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] in_op1_reg,
    input  wire  [7:0]                             in_modrm,
    input  wire  [ra_pipe_pkg::IMM_WIDTH-1:0]      in_imm,
    input  wire  [ra_pipe_pkg::DISP_WIDTH-1:0]     in_disp,
    input  wire  [ra_pipe_pkg::ALU_OP_WIDTH-1:0]   in_alu_op,
    input  wire  [ra_pipe_pkg::PC_WIDTH-1:0]       in_pc,
    input  wire  [x86_arch_pkg::GPR_WIDTH-1:0]     in_gpr_op0,
    input  wire  [x86_arch_pkg::GPR_WIDTH-1:0]     in_gpr_op1,
    input  wire  [x86_arch_pkg::SEG_WIDTH-1:0]     in_seg_val,
    input  wire  [x86_arch_pkg::MMX_WIDTH-1:0]     in_mmx_op0,
    input  wire  [x86_arch_pkg::MMX_WIDTH-1:0]     in_mmx_op1,
    output logic                                   out_valid,
    input  wire                                    out_ready,
    output logic [x86_arch_pkg::SIZE_WIDTH-1:0]    out_size,
    output logic [x86_arch_pkg::OPK_WIDTH-1:0]     out_op0,
    output logic [x86_arch_pkg::OPK_WIDTH-1:0]     out_op1,
    output logic [x86_arch_pkg::REG_NUM_WIDTH-1:0] out_op0_reg,
    output logic [x86_arch_pkg::REG_NUM_WIDTH-1:0] out_op1_reg,
    output logic [7:0]                             out_modrm,
    output logic [ra_pipe_pkg::IMM_WIDTH-1:0]      out_imm,
    output logic [ra_pipe_pkg::DISP_WIDTH-1:0]     out_disp,
    output logic [ra_pipe_pkg::ALU_OP_WIDTH-1:0]   out_alu_op,
    output logic [ra_pipe_pkg::PC_WIDTH-1:0]       out_pc,
    output logic [x86_arch_pkg::GPR_WIDTH-1:0]     out_gpr_op0,
    output logic [x86_arch_pkg::GPR_WIDTH-1:0]     out_gpr_op1,
    output logic [x86_arch_pkg::SEG_WIDTH-1:0]     out_seg_val,
    output logic [x86_arch_pkg::MMX_WIDTH-1:0]     out_mmx_op0,
    output logic [x86_arch_pkg::MMX_WIDTH-1:0]     out_mmx_op1
);

    logic load;

    // Flush keeps decode moving but squashes whatever it offers
    assign in_ready = flush || !out_valid || out_ready;
    assign load     = in_valid && in_ready && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (load) begin
            out_size    <= in_size;
            out_op0     <= in_op0;
            out_op1     <= in_op1;
            out_op0_reg <= in_op0_reg;
            out_op1_reg <= in_op1_reg;
            out_modrm   <= in_modrm;
            out_imm     <= in_imm;
            out_disp    <= in_disp;
            out_alu_op  <= in_alu_op;
            out_pc      <= in_pc;
            out_gpr_op0 <= in_gpr_op0;
            out_gpr_op1 <= in_gpr_op1;
            out_seg_val <= in_seg_val;
            out_mmx_op0 <= in_mmx_op0;
            out_mmx_op1 <= in_mmx_op1;
        end
    end

endmodule

`default_nettype wire

/* hdl/register_access_stage.sv */
/*
 * Register access stage: resolves operand registers, reads the general,
 * segment and MMX register files and registers the result for AGEN
 */
`timescale 1ns/1ps
`default_nettype none

module register_access_stage (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    flush,

    // Decode
    input  wire                                    d_valid,
    output logic                                   d_ready,
    input  wire  [x86_arch_pkg::SIZE_WIDTH-1:0]    d_size,
    input  wire  [x86_arch_pkg::OPK_WIDTH-1:0]     d_op0,
    input  wire  [x86_arch_pkg::OPK_WIDTH-1:0]     d_op1,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] d_op0_reg,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] d_op1_reg,
    input  wire  [7:0]                             d_modrm,
    input  wire  [ra_pipe_pkg::IMM_WIDTH-1:0]      d_imm,
    input  wire  [ra_pipe_pkg::DISP_WIDTH-1:0]     d_disp,
    input  wire  [ra_pipe_pkg::ALU_OP_WIDTH-1:0]   d_alu_op,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] d_seg_override,
    input  wire                                    d_seg_override_valid,
    input  wire  [ra_pipe_pkg::PC_WIDTH-1:0]       d_pc,

    // Address generation
    output logic                                   r_valid,
    input  wire                                    r_ready,
    output logic [x86_arch_pkg::SIZE_WIDTH-1:0]    r_size,
    output logic [x86_arch_pkg::OPK_WIDTH-1:0]     r_op0,
    output logic [x86_arch_pkg::OPK_WIDTH-1:0]     r_op1,
    output logic [x86_arch_pkg::REG_NUM_WIDTH-1:0] r_op0_reg,
    output logic [x86_arch_pkg::REG_NUM_WIDTH-1:0] r_op1_reg,
    output logic [7:0]                             r_modrm,
    output logic [ra_pipe_pkg::IMM_WIDTH-1:0]      r_imm,
    output logic [ra_pipe_pkg::DISP_WIDTH-1:0]     r_disp,
    output logic [ra_pipe_pkg::ALU_OP_WIDTH-1:0]   r_alu_op,
    output logic [ra_pipe_pkg::PC_WIDTH-1:0]       r_pc,
    output logic [x86_arch_pkg::GPR_WIDTH-1:0]     r_gpr_op0,
    output logic [x86_arch_pkg::GPR_WIDTH-1:0]     r_gpr_op1,
    output logic [x86_arch_pkg::SEG_WIDTH-1:0]     r_seg_val,
    output logic [x86_arch_pkg::MMX_WIDTH-1:0]     r_mmx_op0,
    output logic [x86_arch_pkg::MMX_WIDTH-1:0]     r_mmx_op1,

    // Writeback
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] wb_reg_number,
    input  wire                                    wb_reg_en,
    input  wire  [x86_arch_pkg::SIZE_WIDTH-1:0]    wb_reg_size,
    input  wire  [x86_arch_pkg::GPR_WIDTH-1:0]     wb_reg_data,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] wb_seg_number,
    input  wire                                    wb_seg_en,
    input  wire  [x86_arch_pkg::SEG_WIDTH-1:0]     wb_seg_data,
    input  wire  [x86_arch_pkg::REG_NUM_WIDTH-1:0] wb_mmx_number,
    input  wire                                    wb_mmx_en,
    input  wire  [x86_arch_pkg::MMX_WIDTH-1:0]     wb_mmx_data
);

    import x86_arch_pkg::*;
    import ra_pipe_pkg::*;

    modrm_u                               modrm;
    logic [REG_NUM_WIDTH-1:0]             op0_num;
    logic [REG_NUM_WIDTH-1:0]             op1_num;
    logic [REG_NUM_WIDTH-1:0]             seg_select;
    logic [GPR_WIDTH-1:0]                 gpr_op0;
    logic [GPR_WIDTH-1:0]                 gpr_op1;
    wire  [GPR_COUNT-1:0][GPR_BYTES-1:0]  wr_mask;
    wire  [GPR_WIDTH-1:0]                 wr_lanes;
    wire  [GPR_COUNT-1:0][GPR_WIDTH-1:0]  gpr_values;
    wire  [SEG_WIDTH-1:0]                 seg_val;
    wire  [MMX_WIDTH-1:0]                 mmx_val0;
    wire  [MMX_WIDTH-1:0]                 mmx_val1;

    assign modrm.raw = d_modrm;

    // Operand kind 4 names its register through ModRM.reg
    assign op0_num = (d_op0 == OPK_MODRM_REG) ? modrm.f.reg_op : d_op0_reg;
    assign op1_num = (d_op1 == OPK_MODRM_REG) ? modrm.f.reg_op : d_op1_reg;

    assign seg_select = d_seg_override_valid ? d_seg_override : DEFAULT_SEG;

    assign gpr_op0 = gpr_values[op0_num];
    assign gpr_op1 = gpr_values[op1_num];

    gpr_wb_decode u_wb_decode (
        .wb_reg_number (wb_reg_number),
        .wb_reg_en     (wb_reg_en),
        .wb_reg_size   (wb_reg_size),
        .wb_reg_data   (wb_reg_data),
        .wr_mask       (wr_mask),
        .wr_lanes      (wr_lanes)
    );

    // EAX, ECX, EDX, EBX, ESP, EBP, ESI, EDI
    for (genvar i = 0; i < GPR_COUNT; i++) begin : g_gpr
        gpr_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr_byte_en (wr_mask[i]),
            .wr_lanes   (wr_lanes),
            .value      (gpr_values[i])
        );
    end

    seg_mmx_register_file u_seg_mmx (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_seg_number (wb_seg_number),
        .wb_seg_en     (wb_seg_en),
        .wb_seg_data   (wb_seg_data),
        .wb_mmx_number (wb_mmx_number),
        .wb_mmx_en     (wb_mmx_en),
        .wb_mmx_data   (wb_mmx_data),
        .seg_select    (seg_select),
        .mmx_read0     (op0_num),
        .mmx_read1     (op1_num),
        .seg_val       (seg_val),
        .mmx_val0      (mmx_val0),
        .mmx_val1      (mmx_val1)
    );

    // Resolved register numbers travel on, not the raw decode fields
    ra_pipe_reg u_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .in_valid    (d_valid),
        .in_ready    (d_ready),
        .in_size     (d_size),
        .in_op0      (d_op0),
        .in_op1      (d_op1),
        .in_op0_reg  (op0_num),
        .in_op1_reg  (op1_num),
        .in_modrm    (modrm.raw),
        .in_imm      (d_imm),
        .in_disp     (d_disp),
        .in_alu_op   (d_alu_op),
        .in_pc       (d_pc),
        .in_gpr_op0  (gpr_op0),
        .in_gpr_op1  (gpr_op1),
        .in_seg_val  (seg_val),
        .in_mmx_op0  (mmx_val0),
        .in_mmx_op1  (mmx_val1),
        .out_valid   (r_valid),
        .out_ready   (r_ready),
        .out_size    (r_size),
        .out_op0     (r_op0),
        .out_op1     (r_op1),
        .out_op0_reg (r_op0_reg),
        .out_op1_reg (r_op1_reg),
        .out_modrm   (r_modrm),
        .out_imm     (r_imm),
        .out_disp    (r_disp),
        .out_alu_op  (r_alu_op),
        .out_pc      (r_pc),
        .out_gpr_op0 (r_gpr_op0),
        .out_gpr_op1 (r_gpr_op1),
        .out_seg_val (r_seg_val),
        .out_mmx_op0 (r_mmx_op0),
        .out_mmx_op1 (r_mmx_op1)
    );

endmodule

`default_nettype wire

/* bench/tb_ra_tests.svh */
/*
 * Directed tests of the register access stage, with a software model of
 * the general, segment and MMX registers that gives the expected values
 */
`ifndef TB_RA_TESTS_SVH
`define TB_RA_TESTS_SVH

    localparam logic [OPK_WIDTH-1:0] OPK_DIRECT = 3'd1;

    logic [GPR_WIDTH-1:0] gpr_model [GPR_COUNT];
    logic [SEG_WIDTH-1:0] seg_model [SEG_COUNT];
    logic [MMX_WIDTH-1:0] mmx_model [MMX_COUNT];

    // Instruction offered to decode and later checked on the r_ side
    logic [SIZE_WIDTH-1:0]    ins_size;
    logic [OPK_WIDTH-1:0]     ins_op0, ins_op1;
    logic [REG_NUM_WIDTH-1:0] ins_op0_reg, ins_op1_reg, ins_seg_ovr;
    logic                     ins_seg_ovr_v;
    modrm_u                   ins_modrm;
    logic [31:0]              ins_imm, ins_disp, ins_pc;
    logic [ALU_OP_WIDTH-1:0]  ins_alu_op;

    task automatic clear_model();
        gpr_model = '{default: '0};
        seg_model = '{default: '0};
        mmx_model = '{default: '0};
    endtask

    task automatic write_gpr(input logic [REG_NUM_WIDTH-1:0] num,
                             input logic [SIZE_WIDTH-1:0] size, input logic [31:0] data);
        @(posedge clk);
        wb_reg_number <= num;
        wb_reg_size   <= size;
        wb_reg_data   <= data;
        wb_reg_en     <= 1'b1;
        @(posedge clk);
        wb_reg_en     <= 1'b0;
        // Numbers 4 to 7 at byte size are AH, CH, DH, BH
        case (size)
            SIZE_BYTE: begin
                if (!num[2]) begin
                    gpr_model[num][7:0] = data[7:0];
                end else begin
                    gpr_model[{1'b0, num[1:0]}][15:8] = data[7:0];
                end
            end
            SIZE_WORD:  gpr_model[num][15:0] = data[15:0];
            SIZE_DWORD: gpr_model[num] = data;
            default: ;
        endcase
    endtask

    task automatic write_seg_mmx(input logic [REG_NUM_WIDTH-1:0] num,
                                 input logic [15:0] sdata, input logic [63:0] mdata);
        @(posedge clk);
        wb_seg_number <= num;
        wb_seg_data   <= sdata;
        wb_seg_en     <= 1'b1;
        wb_mmx_number <= num;
        wb_mmx_data   <= mdata;
        wb_mmx_en     <= 1'b1;
        @(posedge clk);
        wb_seg_en     <= 1'b0;
        wb_mmx_en     <= 1'b0;
        // No segment register behind 6 and 7
        if (num <= SEG_GS) begin
            seg_model[num] = sdata;
        end
        mmx_model[num] = mdata;
    endtask

    function automatic logic [REG_NUM_WIDTH-1:0] resolve(input logic [OPK_WIDTH-1:0] kind,
                                                         input logic [REG_NUM_WIDTH-1:0] num);
        return (kind == OPK_MODRM_REG) ? ins_modrm.f.reg_op : num;
    endfunction

    task automatic build_instr(input logic [OPK_WIDTH-1:0] op0, op1,
                               input logic [REG_NUM_WIDTH-1:0] op0_reg, op1_reg,
                               input logic [7:0] modrm,
                               input logic [REG_NUM_WIDTH-1:0] seg_ovr,
                               input logic seg_ovr_v);
        ins_op0       = op0;
        ins_op1       = op1;
        ins_op0_reg   = op0_reg;
        ins_op1_reg   = op1_reg;
        ins_modrm.raw = modrm;
        ins_seg_ovr   = seg_ovr;
        ins_seg_ovr_v = seg_ovr_v;
        ins_size      = SIZE_WIDTH'(next_rand());
        ins_alu_op    = ALU_OP_WIDTH'(next_rand());
        ins_imm       = next_rand();
        ins_disp      = next_rand();
        ins_pc        = next_rand();
    endtask

    task automatic offer_instr();
        @(posedge clk);
        d_valid              <= 1'b1;
        d_size               <= ins_size;
        d_op0                <= ins_op0;
        d_op1                <= ins_op1;
        d_op0_reg            <= ins_op0_reg;
        d_op1_reg            <= ins_op1_reg;
        d_modrm              <= ins_modrm.raw;
        d_imm                <= ins_imm;
        d_disp               <= ins_disp;
        d_alu_op             <= ins_alu_op;
        d_seg_override       <= ins_seg_ovr;
        d_seg_override_valid <= ins_seg_ovr_v;
        d_pc                 <= ins_pc;
    endtask

    // Offer, wait for the accept edge, then for r_valid
    task automatic send_instr();
        offer_instr();
        @(negedge clk);
        while (!d_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        d_valid <= 1'b0;
        @(negedge clk);
        while (!r_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic check_outputs();
        logic [REG_NUM_WIDTH-1:0] n0;
        logic [REG_NUM_WIDTH-1:0] n1;
        logic [REG_NUM_WIDTH-1:0] seg;
        n0  = resolve(ins_op0, ins_op0_reg);
        n1  = resolve(ins_op1, ins_op1_reg);
        seg = ins_seg_ovr_v ? ins_seg_ovr : DEFAULT_SEG;
        compare_field("r_size", 64'(ins_size), 64'(r_size));
        compare_field("r_op0", 64'(ins_op0), 64'(r_op0));
        compare_field("r_op1", 64'(ins_op1), 64'(r_op1));
        compare_field("r_op0_reg", 64'(n0), 64'(r_op0_reg));
        compare_field("r_op1_reg", 64'(n1), 64'(r_op1_reg));
        compare_field("r_modrm", 64'(ins_modrm.raw), 64'(r_modrm));
        compare_field("r_imm", 64'(ins_imm), 64'(r_imm));
        compare_field("r_disp", 64'(ins_disp), 64'(r_disp));
        compare_field("r_alu_op", 64'(ins_alu_op), 64'(r_alu_op));
        compare_field("r_pc", 64'(ins_pc), 64'(r_pc));
        compare_field("r_gpr_op0", 64'(gpr_model[n0]), 64'(r_gpr_op0));
        compare_field("r_gpr_op1", 64'(gpr_model[n1]), 64'(r_gpr_op1));
        compare_field("r_seg_val", 64'(seg_model[seg]), 64'(r_seg_val));
        compare_field("r_mmx_op0", mmx_model[n0], r_mmx_op0);
        compare_field("r_mmx_op1", mmx_model[n1], r_mmx_op1);
    endtask

    task automatic read_all_gprs();
        for (int i = 0; i < GPR_COUNT; i += 2) begin
            build_instr(OPK_DIRECT, OPK_DIRECT, REG_NUM_WIDTH'(i), REG_NUM_WIDTH'(i + 1),
                        8'(next_rand()), SEG_ES, 1'b0);
            send_instr();
            check_outputs();
        end
    endtask

    task automatic test_reset();
        current_test = "reset";
        @(negedge clk);
        if (r_valid) begin
            report_error("r_valid is high right after reset");
        end
        if (!d_ready) begin
            report_error("d_ready is low right after reset");
        end
        // ModRM reg field 3 for operand 0
        build_instr(OPK_MODRM_REG, OPK_DIRECT, 3'd0, 3'd7, 8'hd8, SEG_ES, 1'b1);
        send_instr();
        check_outputs();
    endtask

    task automatic test_dword_reads();
        modrm_u m;
        current_test = "dword";
        for (int i = 0; i < GPR_COUNT; i++) begin
            write_gpr(REG_NUM_WIDTH'(i), SIZE_DWORD, next_rand());
        end
        read_all_gprs();
        // Operand 0 always through ModRM.reg and operand 1 on odd passes
        for (int i = 0; i < GPR_COUNT; i++) begin
            m.raw      = 8'(next_rand());
            m.f.reg_op = REG_NUM_WIDTH'(i);
            build_instr(OPK_MODRM_REG, (i % 2 == 1) ? OPK_MODRM_REG : OPK_DIRECT,
                        REG_NUM_WIDTH'(i ^ 5), REG_NUM_WIDTH'(7 - i), m.raw, SEG_ES, 1'b0);
            send_instr();
            check_outputs();
        end
    endtask

    task automatic test_partial_writes();
        current_test = "partial";
        for (int i = 0; i < GPR_COUNT; i++) begin
            write_gpr(REG_NUM_WIDTH'(i), SIZE_BYTE, next_rand());
        end
        read_all_gprs();
        for (int i = 1; i < GPR_COUNT; i += 2) begin
            write_gpr(REG_NUM_WIDTH'(i), SIZE_WORD, next_rand());
        end
        // Unknown size codes leave the register alone
        write_gpr(3'd2, 3'd3, next_rand());
        write_gpr(3'd5, 3'd7, next_rand());
        read_all_gprs();
    endtask

    task automatic test_seg_mmx_reads();
        current_test = "seg_mmx";
        for (int i = 0; i < MMX_COUNT; i++) begin
            write_seg_mmx(REG_NUM_WIDTH'(i), 16'(next_rand()), {next_rand(), next_rand()});
        end
        for (int s = 0; s < SEG_COUNT; s++) begin
            build_instr(OPK_DIRECT, OPK_MODRM_REG, REG_NUM_WIDTH'(s + 2), 3'd0,
                        {2'b11, REG_NUM_WIDTH'(s), 3'd0}, REG_NUM_WIDTH'(s), 1'b1);
            send_instr();
            check_outputs();
        end
        // Override field ignored without its valid bit
        build_instr(OPK_MODRM_REG, OPK_DIRECT, 3'd0, 3'd6, 8'h3a, SEG_GS, 1'b0);
        send_instr();
        check_outputs();
    endtask

    task automatic test_backpressure_flush();
        current_test = "backpressure";
        @(posedge clk);
        r_ready <= 1'b0;
        build_instr(OPK_DIRECT, OPK_MODRM_REG, 3'd4, 3'd0, 8'h51, SEG_SS, 1'b1);
        send_instr();
        check_outputs();
        // Second instruction waits while the first one is held
        @(posedge clk);
        d_valid <= 1'b1;
        d_pc    <= ins_pc + 32'd4;
        d_imm   <= ~ins_imm;
        repeat (4) begin
            @(negedge clk);
            if (d_ready) begin
                report_error("d_ready is high under back-pressure");
            end
            if (!r_valid) begin
                report_error("r_valid dropped under back-pressure");
            end
            check_outputs();
        end
        current_test = "flush";
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        if (!d_ready) begin
            report_error("d_ready is low during flush");
        end
        @(posedge clk);
        flush   <= 1'b0;
        d_valid <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (r_valid) begin
                report_error("r_valid is high after flush");
            end
        end
        current_test = "release";
        build_instr(OPK_MODRM_REG, OPK_DIRECT, 3'd1, 3'd2, 8'h2f, SEG_FS, 1'b1);
        send_instr();
        check_outputs();
        // Next instruction held until address generation raises r_ready
        build_instr(OPK_DIRECT, OPK_DIRECT, 3'd6, 3'd3, 8'h94, SEG_CS, 1'b1);
        offer_instr();
        @(negedge clk);
        if (d_ready) begin
            report_error("d_ready is high while the output is held");
        end
        @(posedge clk);
        r_ready <= 1'b1;
        @(negedge clk);
        if (!d_ready) begin
            report_error("d_ready is low after r_ready rises");
        end
        @(posedge clk);
        d_valid <= 1'b0;
        @(negedge clk);
        if (!r_valid) begin
            report_error("r_valid is low after the released transfer");
        end
        check_outputs();
    endtask

`endif

/* bench/tb_register_access.sv */
/*
 * Register access stage testbench: clock, reset, random data source,
 * timeout and the ordered run of the directed tests
 */
`timescale 1ns/1ps
`default_nettype none

module tb_register_access;

    import x86_arch_pkg::*;
    import ra_pipe_pkg::*;

    localparam int CLK_PERIOD     = 4;
    // Whole sequence is a few hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                     clk, rst_n, flush;
    logic                     d_valid, d_seg_override_valid, r_ready;
    wire                      d_ready, r_valid;
    logic [SIZE_WIDTH-1:0]    d_size;
    logic [OPK_WIDTH-1:0]     d_op0, d_op1;
    logic [REG_NUM_WIDTH-1:0] d_op0_reg, d_op1_reg, d_seg_override;
    logic [7:0]               d_modrm;
    logic [IMM_WIDTH-1:0]     d_imm;
    logic [DISP_WIDTH-1:0]    d_disp;
    logic [ALU_OP_WIDTH-1:0]  d_alu_op;
    logic [PC_WIDTH-1:0]      d_pc;
    wire  [SIZE_WIDTH-1:0]    r_size;
    wire  [OPK_WIDTH-1:0]     r_op0, r_op1;
    wire  [REG_NUM_WIDTH-1:0] r_op0_reg, r_op1_reg;
    wire  [7:0]               r_modrm;
    wire  [IMM_WIDTH-1:0]     r_imm;
    wire  [DISP_WIDTH-1:0]    r_disp;
    wire  [ALU_OP_WIDTH-1:0]  r_alu_op;
    wire  [PC_WIDTH-1:0]      r_pc;
    wire  [GPR_WIDTH-1:0]     r_gpr_op0, r_gpr_op1;
    wire  [SEG_WIDTH-1:0]     r_seg_val;
    wire  [MMX_WIDTH-1:0]     r_mmx_op0, r_mmx_op1;
    logic [REG_NUM_WIDTH-1:0] wb_reg_number, wb_seg_number, wb_mmx_number;
    logic                     wb_reg_en, wb_seg_en, wb_mmx_en;
    logic [SIZE_WIDTH-1:0]    wb_reg_size;
    logic [GPR_WIDTH-1:0]     wb_reg_data;
    logic [SEG_WIDTH-1:0]     wb_seg_data;
    logic [MMX_WIDTH-1:0]     wb_mmx_data;

    int unsigned errors;
    int unsigned checks;
    int          cycle_count;
    logic [31:0] lcg_state;
    string       current_test;

    register_access_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 32-bit LCG step
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_field(input string field, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s %s: expected %0h, actual %0h",
                     current_test, field, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR %s: %s", current_test, what);
    endtask

    task automatic release_reset();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    `include "tb_ra_tests.svh"

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR timeout: tests still running after %0d cycles", cycle_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        lcg_state = 32'hf9c4_f4ae;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        r_ready   = 1'b1;
        d_valid   = 1'b0;
        d_size    = '0;
        d_op0     = '0;
        d_op1     = '0;
        d_op0_reg = '0;
        d_op1_reg = '0;
        d_modrm   = '0;
        d_imm     = '0;
        d_disp    = '0;
        d_alu_op  = '0;
        d_pc      = '0;
        d_seg_override       = '0;
        d_seg_override_valid = 1'b0;
        wb_reg_number = '0;
        wb_reg_en     = 1'b0;
        wb_reg_size   = '0;
        wb_reg_data   = '0;
        wb_seg_number = '0;
        wb_seg_en     = 1'b0;
        wb_seg_data   = '0;
        wb_mmx_number = '0;
        wb_mmx_en     = 1'b0;
        wb_mmx_data   = '0;
        clear_model();
        release_reset();
        test_reset();
        test_dword_reads();
        test_partial_writes();
        test_seg_mmx_reads();
        test_backpressure_flush();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
hdl/x86_arch_pkg.sv
hdl/ra_pipe_pkg.sv
hdl/gpr_wb_decode.sv
hdl/gpr_entry.sv
hdl/seg_mmx_register_file.sv
hdl/ra_pipe_reg.sv
hdl/register_access_stage.sv
bench/tb_register_access.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register access stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_register_access -Mdir obj_dir -f compile.f

./obj_dir/Vtb_register_access > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
